// ==== hdl/axil_mem_pkg.sv ====
package axil_mem_pkg;

  // AXI4-Lite channel sizes
  localparam int axil_data_width = 32;
  localparam int axil_addr_width = 32;
  localparam int axil_mask_width = axil_data_width >> 3;
  localparam logic [1:0] axil_resp_okay = 2'b00;

  // Memory organisation, 4 slices of 64 words gives 1 KB
  localparam int num_slices = 4;
  localparam int slice_words = 64;
  localparam int slice_id_width = 2;
  localparam int index_width = 6;
  localparam int mem_byte_width = 2;
  localparam int mem_addr_width = slice_id_width + index_width + mem_byte_width;

  // Commands in flight, shared by client and collector
  localparam int num_outstanding = 4;
  localparam int outstanding_cnt_width = 3;
  localparam int order_ptr_width = 2;

  typedef enum logic [1:0]
  {
    e_mem_uc_rd = 2'd0,
    e_mem_uc_wr = 2'd1
  } mem_msg_e;

  typedef enum logic [1:0]
  {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2
  } mem_size_e;

  // Address split as seen by dispatcher and slice
  typedef struct packed
  {
    logic [slice_id_width-1:0] slice;
    logic [index_width-1:0]    index;
    logic [mem_byte_width-1:0] byte_off;
  } mem_addr_fields_s;

  typedef union packed
  {
    logic [mem_addr_width-1:0] flat;
    mem_addr_fields_s          fields;
  } mem_addr_u;

  // Shared by commands and responses
  typedef struct packed
  {
    mem_msg_e  msg_type;
    mem_size_e size;
    mem_addr_u addr;
  } mem_header_s;

endpackage

// ==== hdl/bedrock_stream_if.sv ====
`timescale 1ns/1ps

interface bedrock_stream_if;
  import axil_mem_pkg::*;

  // Single-beat message, last mirrors v
  mem_header_s                header;
  logic [axil_data_width-1:0] data;
  logic                       v;
  logic                       ready_and;
  logic                       last;

  modport producer
  (
    output header,
    output data,
    output v,
    output last,
    input  ready_and
  );

  modport consumer
  (
    input  header,
    input  data,
    input  v,
    input  last,
    output ready_and
  );

endinterface

// ==== hdl/axil_mem_client.sv ====
`timescale 1ns/1ps

module axil_mem_client
  (
    input  logic                                     clk_i,
    input  logic                                     reset_i,

    input  logic [axil_mem_pkg::axil_addr_width-1:0] s_axil_awaddr_i,
    input  logic                                     s_axil_awvalid_i,
    output logic                                     s_axil_awready_o,

    input  logic [axil_mem_pkg::axil_data_width-1:0] s_axil_wdata_i,
    input  logic [axil_mem_pkg::axil_mask_width-1:0] s_axil_wstrb_i,
    input  logic                                     s_axil_wvalid_i,
    output logic                                     s_axil_wready_o,

    output logic [1:0]                               s_axil_bresp_o,
    output logic                                     s_axil_bvalid_o,
    input  logic                                     s_axil_bready_i,

    input  logic [axil_mem_pkg::axil_addr_width-1:0] s_axil_araddr_i,
    input  logic                                     s_axil_arvalid_i,
    output logic                                     s_axil_arready_o,

    output logic [axil_mem_pkg::axil_data_width-1:0] s_axil_rdata_o,
    output logic [1:0]                               s_axil_rresp_o,
    output logic                                     s_axil_rvalid_o,
    input  logic                                     s_axil_rready_i,

    bedrock_stream_if.producer                       fwd_o,
    bedrock_stream_if.consumer                       rev_i
  );
  import axil_mem_pkg::*;

  logic [outstanding_cnt_width-1:0] outstanding_r;
  logic                             rd_prio_r;
  logic                             can_accept;
  logic                             wr_go;
  logic                             rd_go;
  logic                             b_done;
  logic                             r_done;

  logic                             fwd_v_r;
  mem_header_s                      fwd_header_r;
  logic [axil_data_width-1:0]       fwd_data_r;

  mem_size_e                        wr_size;
  logic [mem_byte_width-1:0]        wr_off;
  mem_header_s                      wr_header;
  mem_header_s                      rd_header;

  logic                             rsp_is_wr;
  logic                             rsp_fire;
  logic                             b_v_r;
  logic                             r_v_r;
  logic [axil_data_width-1:0]       r_data_r;

  // New request only with room in flight and a free forward register
  assign can_accept = (!fwd_v_r || fwd_o.ready_and)
                   && (outstanding_r != outstanding_cnt_width'(num_outstanding));

  // Alternate when both pending, write goes first
  assign wr_go = can_accept && s_axil_awvalid_i && s_axil_wvalid_i
              && (!s_axil_arvalid_i || !rd_prio_r);
  assign rd_go = can_accept && s_axil_arvalid_i && !wr_go;

  assign s_axil_awready_o = wr_go;
  assign s_axil_wready_o  = wr_go;
  assign s_axil_arready_o = rd_go;

  // Strobe pattern to size and byte offset
  always_comb
  begin
    wr_size = e_size_4;
    wr_off  = '0;
    case (s_axil_wstrb_i)
      4'b0001: begin wr_size = e_size_1; wr_off = 2'd0; end
      4'b0010: begin wr_size = e_size_1; wr_off = 2'd1; end
      4'b0100: begin wr_size = e_size_1; wr_off = 2'd2; end
      4'b1000: begin wr_size = e_size_1; wr_off = 2'd3; end
      4'b0011: begin wr_size = e_size_2; wr_off = 2'd0; end
      4'b1100: begin wr_size = e_size_2; wr_off = 2'd2; end
      default: begin wr_size = e_size_4; wr_off = 2'd0; end
    endcase
  end

  // Upper address bits are dropped, so the space aliases every 1 KB
  always_comb
  begin
    wr_header           = '0;
    wr_header.msg_type  = e_mem_uc_wr;
    wr_header.size      = wr_size;
    wr_header.addr.flat = {s_axil_awaddr_i[mem_addr_width-1:mem_byte_width], wr_off};

    rd_header           = '0;
    rd_header.msg_type  = e_mem_uc_rd;
    rd_header.size      = e_size_4;
    rd_header.addr.flat = {s_axil_araddr_i[mem_addr_width-1:mem_byte_width],
                           mem_byte_width'(0)};
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      fwd_v_r   <= 1'b0;
      rd_prio_r <= 1'b0;
    end
    else
    begin
      if (wr_go || rd_go)
      begin
        fwd_v_r <= 1'b1;
      end
      else if (fwd_o.ready_and)
      begin
        fwd_v_r <= 1'b0;
      end

      if (wr_go)
      begin
        rd_prio_r <= 1'b1;
      end
      else if (rd_go)
      begin
        rd_prio_r <= 1'b0;
      end
    end
  end

  // Narrow write data moves down to bit 0
  always_ff @(posedge clk_i)
  begin
    if (wr_go)
    begin
      fwd_header_r <= wr_header;
      fwd_data_r   <= s_axil_wdata_i >> {wr_off, 3'b000};
    end
    else if (rd_go)
    begin
      fwd_header_r <= rd_header;
      fwd_data_r   <= '0;
    end
  end

  assign fwd_o.v      = fwd_v_r;
  assign fwd_o.last   = fwd_v_r;
  assign fwd_o.header = fwd_header_r;
  assign fwd_o.data   = fwd_data_r;

  // Response waits while its B or R slot is still full
  assign rsp_is_wr       = (rev_i.header.msg_type == e_mem_uc_wr);
  assign rev_i.ready_and = rsp_is_wr ? !b_v_r : !r_v_r;
  assign rsp_fire        = rev_i.v && rev_i.ready_and;

  assign b_done = b_v_r && s_axil_bready_i;
  assign r_done = r_v_r && s_axil_rready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      b_v_r         <= 1'b0;
      r_v_r         <= 1'b0;
      outstanding_r <= '0;
    end
    else
    begin
      if (rsp_fire && rsp_is_wr)
      begin
        b_v_r <= 1'b1;
      end
      else if (b_done)
      begin
        b_v_r <= 1'b0;
      end

      if (rsp_fire && !rsp_is_wr)
      begin
        r_v_r <= 1'b1;
      end
      else if (r_done)
      begin
        r_v_r <= 1'b0;
      end

      // Counts until the AXI response leaves
      outstanding_r <= outstanding_r
                     + outstanding_cnt_width'(wr_go || rd_go)
                     - outstanding_cnt_width'(b_done)
                     - outstanding_cnt_width'(r_done);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rsp_fire && !rsp_is_wr)
    begin
      r_data_r <= rev_i.data;
    end
  end

  assign s_axil_bvalid_o = b_v_r;
  assign s_axil_bresp_o  = axil_resp_okay;
  assign s_axil_rvalid_o = r_v_r;
  assign s_axil_rdata_o  = r_data_r;
  assign s_axil_rresp_o  = axil_resp_okay;

endmodule

// ==== hdl/mem_fwd_dispatch.sv ====
`timescale 1ns/1ps

module mem_fwd_dispatch
  (
    bedrock_stream_if.consumer                  fwd_i,
    bedrock_stream_if.producer                  slice_fwd_o [axil_mem_pkg::num_slices],
    output logic                                issue_v_o,
    output logic [axil_mem_pkg::slice_id_width-1:0] issue_slice_o,
    input  logic                                issue_ready_i
  );
  import axil_mem_pkg::*;

  logic [slice_id_width-1:0] sel;
  logic [num_slices-1:0]     slice_ready;
  logic [num_slices-1:0]     slice_v;

  // Slice number comes from the top address bits
  assign sel = fwd_i.header.addr.fields.slice;

  for (genvar k = 0; k < num_slices; k++)
  begin : g_slice
    // Only the selected slice sees v, and only with room in the order FIFO
    assign slice_v[k] = fwd_i.v && issue_ready_i && (sel == slice_id_width'(k));

    assign slice_fwd_o[k].v      = slice_v[k];
    assign slice_fwd_o[k].last   = slice_v[k];
    assign slice_fwd_o[k].header = fwd_i.header;
    assign slice_fwd_o[k].data   = fwd_i.data;

    assign slice_ready[k] = slice_fwd_o[k].ready_and;
  end

  assign fwd_i.ready_and = slice_ready[sel] && issue_ready_i;

  // Tell the collector where this command went
  assign issue_v_o     = fwd_i.v && fwd_i.ready_and;
  assign issue_slice_o = sel;

endmodule

// ==== hdl/mem_slice.sv ====
`timescale 1ns/1ps

module mem_slice
  (
    input  logic               clk_i,
    input  logic               reset_i,
    bedrock_stream_if.consumer fwd_i,
    bedrock_stream_if.producer rev_o
  );
  import axil_mem_pkg::*;

  logic [axil_data_width-1:0] mem_r [slice_words];

  logic [index_width-1:0]     idx;
  logic [mem_byte_width-1:0]  off;
  logic                       cmd_fire;
  logic                       wr_fire;
  logic [axil_mask_width-1:0] lane_en;
  logic [axil_data_width-1:0] wdata_lanes;

  logic                       rsp_v_r;
  mem_header_s                rsp_header_r;
  logic [axil_data_width-1:0] rsp_data_r;

  assign idx = fwd_i.header.addr.fields.index;
  assign off = fwd_i.header.addr.fields.byte_off;

  // Room when empty or draining this cycle
  assign fwd_i.ready_and = !rsp_v_r || rev_o.ready_and;
  assign cmd_fire        = fwd_i.v && fwd_i.ready_and;
  assign wr_fire         = cmd_fire && (fwd_i.header.msg_type == e_mem_uc_wr);

  always_comb
  begin
    case (fwd_i.header.size)
      e_size_1: lane_en = 4'b0001 << off;
      e_size_2: lane_en = 4'b0011 << off;
      default:  lane_en = 4'b1111;
    endcase
  end

  // Data arrives at bit 0, move it up to its lanes
  assign wdata_lanes = fwd_i.data << {off, 3'b000};

  always_ff @(posedge clk_i)
  begin
    for (int b = 0; b < axil_mask_width; b++)
    begin
      if (wr_fire && lane_en[b])
      begin
        mem_r[idx][b*8 +: 8] <= wdata_lanes[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rsp_v_r <= 1'b0;
    end
    else if (cmd_fire)
    begin
      rsp_v_r <= 1'b1;
    end
    else if (rev_o.ready_and)
    begin
      rsp_v_r <= 1'b0;
    end
  end

  // Write acks carry no data
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      rsp_header_r <= fwd_i.header;
      rsp_data_r   <= wr_fire ? '0 : mem_r[idx];
    end
  end

  assign rev_o.v      = rsp_v_r;
  assign rev_o.last   = rsp_v_r;
  assign rev_o.header = rsp_header_r;
  assign rev_o.data   = rsp_data_r;

endmodule

// ==== hdl/mem_rev_collect.sv ====
`timescale 1ns/1ps

module mem_rev_collect
  (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  logic                                    issue_v_i,
    input  logic [axil_mem_pkg::slice_id_width-1:0] issue_slice_i,
    output logic                                    issue_ready_o,
    bedrock_stream_if.consumer                      slice_rev_i [axil_mem_pkg::num_slices],
    bedrock_stream_if.producer                      rev_o
  );
  import axil_mem_pkg::*;

  logic [slice_id_width-1:0]        order_r [num_outstanding];
  logic [order_ptr_width-1:0]       wr_ptr_r;
  logic [order_ptr_width-1:0]       rd_ptr_r;
  logic [outstanding_cnt_width-1:0] count_r;
  logic [slice_id_width-1:0]        head;
  logic                             empty;
  logic                             push;
  logic                             pop;

  logic [num_slices-1:0]            v_arr;
  mem_header_s                      header_arr [num_slices];
  logic [axil_data_width-1:0]       data_arr [num_slices];

  assign empty         = (count_r == '0);
  assign issue_ready_o = (count_r != outstanding_cnt_width'(num_outstanding));
  assign head          = order_r[rd_ptr_r];

  for (genvar k = 0; k < num_slices; k++)
  begin : g_slice
    assign v_arr[k]      = slice_rev_i[k].v;
    assign header_arr[k] = slice_rev_i[k].header;
    assign data_arr[k]   = slice_rev_i[k].data;
    // Other slices wait their turn
    assign slice_rev_i[k].ready_and = !empty && (head == slice_id_width'(k))
                                   && rev_o.ready_and;
  end

  assign rev_o.v      = !empty && v_arr[head];
  assign rev_o.last   = !empty && v_arr[head];
  assign rev_o.header = header_arr[head];
  assign rev_o.data   = data_arr[head];

  assign push = issue_v_i && issue_ready_o;
  assign pop  = rev_o.v && rev_o.ready_and;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      count_r <= count_r + outstanding_cnt_width'(push) - outstanding_cnt_width'(pop);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      order_r[wr_ptr_r] <= issue_slice_i;
    end
  end

endmodule

// ==== hdl/axil_mem_top.sv ====
`timescale 1ns/1ps

module axil_mem_top
  (
    input  logic                                     clk_i,
    input  logic                                     reset_i,

    input  logic [axil_mem_pkg::axil_addr_width-1:0] s_axil_awaddr_i,
    input  logic                                     s_axil_awvalid_i,
    output logic                                     s_axil_awready_o,

    input  logic [axil_mem_pkg::axil_data_width-1:0] s_axil_wdata_i,
    input  logic [axil_mem_pkg::axil_mask_width-1:0] s_axil_wstrb_i,
    input  logic                                     s_axil_wvalid_i,
    output logic                                     s_axil_wready_o,

    output logic [1:0]                               s_axil_bresp_o,
    output logic                                     s_axil_bvalid_o,
    input  logic                                     s_axil_bready_i,

    input  logic [axil_mem_pkg::axil_addr_width-1:0] s_axil_araddr_i,
    input  logic                                     s_axil_arvalid_i,
    output logic                                     s_axil_arready_o,

    output logic [axil_mem_pkg::axil_data_width-1:0] s_axil_rdata_o,
    output logic [1:0]                               s_axil_rresp_o,
    output logic                                     s_axil_rvalid_o,
    input  logic                                     s_axil_rready_i
  );
  import axil_mem_pkg::*;

  logic                      issue_v;
  logic [slice_id_width-1:0] issue_slice;
  logic                      issue_ready;

  bedrock_stream_if fwd ();
  bedrock_stream_if rev ();
  bedrock_stream_if slice_fwd [num_slices] ();
  bedrock_stream_if slice_rev [num_slices] ();

  axil_mem_client u_client
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .fwd_o            (fwd),
    .rev_i            (rev)
  );

  mem_fwd_dispatch u_dispatch
  (
    .fwd_i         (fwd),
    .slice_fwd_o   (slice_fwd),
    .issue_v_o     (issue_v),
    .issue_slice_o (issue_slice),
    .issue_ready_i (issue_ready)
  );

  for (genvar k = 0; k < num_slices; k++)
  begin : g_slice
    mem_slice u_slice
    (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .fwd_i   (slice_fwd[k]),
      .rev_o   (slice_rev[k])
    );
  end

  mem_rev_collect u_collect
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .issue_v_i     (issue_v),
    .issue_slice_i (issue_slice),
    .issue_ready_o (issue_ready),
    .slice_rev_i   (slice_rev),
    .rev_o         (rev)
  );

endmodule

// ==== verification/axil_mem_asserts.sv ====
`timescale 1ns/1ps

module axil_mem_asserts
  (
    input logic                                           clk_i,
    input logic                                           reset_i,
    input logic                                           bvalid_i,
    input logic                                           bready_i,
    input logic                                           rvalid_i,
    input logic                                           rready_i,
    input logic [axil_mem_pkg::axil_data_width-1:0]       rdata_i,
    input logic                                           fwd_v_i,
    input logic                                           fwd_ready_i,
    input axil_mem_pkg::mem_header_s                      fwd_header_i,
    input logic [axil_mem_pkg::outstanding_cnt_width-1:0] outstanding_i
  );
  import axil_mem_pkg::*;

  int fail_count = 0;

  b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_i && !bready_i |=> bvalid_i)
  else
  begin
    fail_count++;
    $error("bvalid dropped before bready");
  end

  r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
  else
  begin
    fail_count++;
    $error("rvalid or rdata changed before rready");
  end

  // Forward command held steady until the dispatcher takes it
  fwd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    fwd_v_i && !fwd_ready_i |=> fwd_v_i && $stable(fwd_header_i))
  else
  begin
    fail_count++;
    $error("forward command changed before its transfer");
  end

  count_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding_i <= outstanding_cnt_width'(num_outstanding))
  else
  begin
    fail_count++;
    $error("outstanding count above its limit");
  end

endmodule

bind axil_mem_client axil_mem_asserts u_asserts
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .bvalid_i      (s_axil_bvalid_o),
    .bready_i      (s_axil_bready_i),
    .rvalid_i      (s_axil_rvalid_o),
    .rready_i      (s_axil_rready_i),
    .rdata_i       (s_axil_rdata_o),
    .fwd_v_i       (fwd_v_r),
    .fwd_ready_i   (fwd_o.ready_and),
    .fwd_header_i  (fwd_header_r),
    .outstanding_i (outstanding_r)
  );

// ==== verification/axil_mem_tb.sv ====
`timescale 1ns/1ps

module axil_mem_tb;
  import axil_mem_pkg::*;

  localparam string case_file = "verification/axil_mem_cases.txt";

  // AXI OKAY response code
  localparam logic [1:0] okay_resp = 2'b00;

  logic        clk;
  logic        reset;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  // Byte-accurate copy of the 1 KB space
  logic [31:0] model_mem [256];
  logic [31:0] stall_addr [5];

  string       c_op [$];
  string       c_name [$];
  logic [31:0] c_addr [$];
  logic [31:0] c_wdata [$];
  logic [3:0]  c_strb [$];
  logic [31:0] c_expect [$];

  // Responses still owed in issue order
  string       wr_names [$];
  string       rd_names [$];
  logic [31:0] rd_expect [$];

  int          tests_run = 0;
  int          tests_failed = 0;
  int          other_errors = 0;
  int          limit_cycles = 1000;
  bit          cases_loaded = 1'b0;
  bit          hold_rready = 1'b0;
  logic [31:0] lfsr_state;

  axil_mem_top i_dut
  (
    .clk_i            (clk),
    .reset_i          (reset),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Byte, aligned half and word strobes are kept and anything else writes the whole word
  function automatic logic [3:0] lanes_of(input logic [3:0] strb);
    case (strb)
      4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100: return strb;
      default: return 4'b1111;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v, inout bit ok);
    assert (act_v === exp_v)
    else
    begin
      $display("Error: test %s expected %h actual %h", name, exp_v, act_v);
      ok = 1'b0;
    end
  endtask

  task automatic report_test(input string name, input bit ok);
    tests_run++;
    if (!ok)
    begin
      tests_failed++;
    end
    $display("test %s: %s", name, ok ? "ok" : "failed");
  endtask

  task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input string name);
    logic [3:0] lanes;
    lanes = lanes_of(strb);
    for (int b = 0; b < 4; b++)
    begin
      if (lanes[b])
      begin
        model_mem[addr[9:2]][b*8 +: 8] = data[b*8 +: 8];
      end
    end
    wr_names.push_back(name);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // Address and data ready rise together
    do
    begin
      @(negedge clk);
      assert (awready === wready)
      else
      begin
        $display("awready and wready did not rise in the same cycle for %s", name);
        other_errors++;
      end
    end
    while (!(awready && wready));
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic send_read(input logic [31:0] addr, input string name);
    rd_names.push_back(name);
    rd_expect.push_back(model_mem[addr[9:2]]);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
  endtask

  task automatic wait_drained();
    while (wr_names.size() != 0 || rd_names.size() != 0)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #2 clk = ~clk;
    end
  end

  // Random low periods on both response readies
  initial
  begin
    lfsr_state = 32'hfd5b;
    bready     = 1'b0;
    rready     = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      lfsr_state = lfsr_next(lfsr_state);
      bready     = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
      rready     = lfsr_state[0] && !hold_rready;
    end
  end

  // Sampled mid-cycle since the transfer itself happens on the next rising edge
  initial
  begin : check_responses
    string name;
    logic [31:0] exp_v;
    bit ok;
    forever
    begin
      @(negedge clk);
      if (bvalid && bready)
      begin
        assert (wr_names.size() != 0)
        else
        begin
          $display("A write response arrived with no write outstanding");
          other_errors++;
        end
        if (wr_names.size() != 0)
        begin
          name = wr_names.pop_front();
          ok   = 1'b1;
          check_value(name, 32'(okay_resp), 32'(bresp), ok);
          report_test(name, ok);
        end
      end
      if (rvalid && rready)
      begin
        assert (rd_names.size() != 0)
        else
        begin
          $display("A read response arrived with no read outstanding");
          other_errors++;
        end
        if (rd_names.size() != 0)
        begin
          name  = rd_names.pop_front();
          exp_v = rd_expect.pop_front();
          ok    = 1'b1;
          check_value(name, exp_v, rdata, ok);
          check_value(name, 32'(okay_resp), 32'(rresp), ok);
          report_test(name, ok);
        end
      end
    end
  end

  initial
  begin : watchdog
    wait (cases_loaded);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin : main
    int fd;
    int n;
    string line;
    string op;
    string name;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_v;
    logic [3:0] strb;
    bit ok;
    int assert_fails;

    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    stall_addr[0] = 32'h000;
    stall_addr[1] = 32'h104;
    stall_addr[2] = 32'h208;
    stall_addr[3] = 32'h30c;
    stall_addr[4] = 32'h010;

    fd = $fopen(case_file, "r");
    assert (fd != 0)
    else
    begin
      $display("Could not open the case file %s", case_file);
      other_errors++;
    end
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#")
        begin
          n = $sscanf(line, "%s %h %h %h %h %s", op, addr, data, strb, exp_v, name);
          if (n == 6)
          begin
            c_op.push_back(op);
            c_addr.push_back(addr);
            c_wdata.push_back(data);
            c_strb.push_back(strb);
            c_expect.push_back(exp_v);
            c_name.push_back(name);
          end
        end
      end
      $fclose(fd);
    end
    assert (c_op.size() > 0)
    else
    begin
      $display("The case file held no usable cases");
      other_errors++;
    end
    limit_cycles = c_op.size() * 200 + 1000;
    cases_loaded = 1'b1;

    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // Nothing may answer before a request
    ok = 1'b1;
    repeat (8)
    begin
      @(negedge clk);
      assert (!bvalid && !rvalid)
      else
      begin
        $display("A response valid rose with no request sent");
        ok = 1'b0;
      end
    end
    report_test("idle_after_reset", ok);
    @(posedge clk);
    #1;

    foreach (c_op[i])
    begin
      if (c_op[i] == "W")
      begin
        send_write(c_addr[i], c_wdata[i], c_strb[i], c_name[i]);
      end
      else
      begin
        assert (c_expect[i] === model_mem[c_addr[i][9:2]])
        else
        begin
          $display("Error: test %s case file expects %h but model holds %h",
                   c_name[i], c_expect[i], model_mem[c_addr[i][9:2]]);
          other_errors++;
        end
        send_read(c_addr[i], c_name[i]);
      end
    end
    wait_drained();

    // Fill every outstanding slot with rready low, then one more read must wait
    hold_rready = 1'b1;
    @(posedge clk);
    #1;
    for (int k = 0; k < 4; k++)
    begin
      send_read(stall_addr[k], $sformatf("stall_rd%0d", k));
    end
    rd_names.push_back("stall_rd4");
    rd_expect.push_back(model_mem[stall_addr[4][9:2]]);
    araddr  = stall_addr[4];
    arvalid = 1'b1;
    ok      = 1'b1;
    repeat (12)
    begin
      @(negedge clk);
      assert (!arready)
      else
      begin
        $display("arready rose while all outstanding slots were in use");
        ok = 1'b0;
      end
    end
    hold_rready = 1'b0;
    @(negedge clk);
    while (!arready)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    report_test("arready_blocked", ok);
    wait_drained();
    repeat (4) @(posedge clk);

    assert_fails = i_dut.u_client.u_asserts.fail_count;
    $display("tests run %0d, failed %0d, other errors %0d, assertion failures %0d",
             tests_run, tests_failed, other_errors, assert_fails);
    if (tests_failed == 0 && other_errors == 0 && assert_fails == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== verification/axil_mem_cases.txt ====
# op addr wdata strb expect name, all numbers hex
# op is W or R, expect is the read data and is unused on writes
W 00000000 11223344 f 00000000 full_wr_s0
W 00000104 55667788 f 00000000 full_wr_s1
W 00000208 99aabbcc f 00000000 full_wr_s2
W 0000030c ddeeff00 f 00000000 full_wr_s3
R 00000000 00000000 0 11223344 full_rd_s0
R 00000104 00000000 0 55667788 full_rd_s1
R 00000208 00000000 0 99aabbcc full_rd_s2
R 0000030c 00000000 0 ddeeff00 full_rd_s3
W 00000010 a5a5a5a5 f 00000000 byte_base_wr
W 00000010 00003c00 2 00000000 byte_lane1_wr
R 00000010 00000000 0 a5a53ca5 byte_merge_rd
W 00000014 f0f0f0f0 f 00000000 half_base_wr
W 00000014 12340000 c 00000000 half_upper_wr
W 00000014 00000056 1 00000000 byte_lane0_wr
R 00000014 00000000 0 1234f056 half_merge_rd
W 00000018 cafef00d 6 00000000 odd_strb_wr
R 00000018 00000000 0 cafef00d odd_strb_rd
W 00001620 0badcafe f 00000000 alias_wr
R 00000220 00000000 0 0badcafe alias_rd_low
R 0000fe20 00000000 0 0badcafe alias_rd_high
W 00000124 13579bdf f 00000000 mix_wr_s1
R 00000000 00000000 0 11223344 mix_rd_s0
W 00000328 2468ace0 f 00000000 mix_wr_s3
R 00000124 00000000 0 13579bdf mix_rd_s1
R 00000328 00000000 0 2468ace0 mix_rd_s3
R 00000010 00000000 0 a5a53ca5 mix_rd_s0b
W 0000032c deadbeef f 00000000 mix_wr_s3b
R 0000032c 00000000 0 deadbeef mix_rd_s3b

// ==== files.f ====
hdl/axil_mem_pkg.sv
hdl/bedrock_stream_if.sv
hdl/axil_mem_client.sv
hdl/mem_fwd_dispatch.sv
hdl/mem_slice.sv
hdl/mem_rev_collect.sv
hdl/axil_mem_top.sv
verification/axil_mem_asserts.sv
verification/axil_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module axil_mem_tb -f files.f -o axil_mem_sim

status=0
./obj_dir/axil_mem_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
